// ==== flist.f ====
design/aluPkg.sv
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/flagReg.sv
design/execUnit.sv
verif/execUnit_chk.sv
verif/execUnitTb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := execUnitTb
FLIST     := flist.f
OBJDIR    := obj_dir
LOG       := sim.log
RUNARGS   := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verif/execUnitTb.sv ====
`timescale 1ns/1ps

module execUnitTb import aluPkg::*, cpuPkg::*;;

	// ----------------------------------------
	// Run length.
	// ----------------------------------------

	localparam int clkPeriod   = 40;
	localparam int resetCycles = 2;
	localparam int numLoads    = 16;
	localparam int numArith    = 24;
	localparam int numCmp      = 8;
	localparam int numLogic    = 28;
	localparam int numUndef    = 6;
	// Directed instructions and idle cycles around the loops.
	localparam int numDirected = 40;
	localparam int totalInsts  = numLoads + numArith + numCmp + numLogic + numUndef + numDirected;

	logic  clk = 1'b0;
	logic  rst;
	logic  instValid;
	instT  inst;
	wordT  result;
	logic  resultValid;
	flagsT flags;

	logic [31:0] lfsrState = 32'hb39b;

	// Reference model state.
	wordT  mRegs [numRegs];
	flagsT mFlags;
	wordT  expResult;
	logic  expValid;
	logic  checking = 1'b0;

	always #(clkPeriod / 2) clk = ~clk;

	execUnit u_execUnit (
		.clk         (clk),
		.rst         (rst),
		.instValid   (instValid),
		.inst        (inst),
		.result      (result),
		.resultValid (resultValid),
		.flags       (flags)
	);

	// ----------------------------------------
	// Random source.
	// ----------------------------------------

	// Taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
		return val;
	endfunction

	// ----------------------------------------
	// Reference model.
	// ----------------------------------------

	task automatic setCompareFlags(input wordT a, input wordT b);
		mFlags[flagL] = a < b;
		mFlags[flagZ] = a == b;
		mFlags[flagN] = $signed(a) < $signed(b);
	endtask

	task automatic modelExec(input instT i);
		wordT           a;
		wordT           b;
		wordT           res;
		logic [wordW:0] sum;
		logic           writes;
		a = mRegs[i.rdest];
		b = i.useImm ? {{(wordW - immW){i.imm[immW-1]}}, i.imm} : mRegs[i.rsrc];
		res = '0;
		writes = 1'b1;
		case (i.opCode)
			opAdd: begin
				sum = {1'b0, a} + {1'b0, b};
				res = sum[wordW-1:0];
				mFlags[flagC] = sum[wordW];
				mFlags[flagF] = (a[wordW-1] == b[wordW-1]) && (res[wordW-1] != a[wordW-1]);
				setCompareFlags(a, b);
			end
			opSub: begin
				// No borrow means carry set.
				res = a - b;
				mFlags[flagC] = a >= b;
				mFlags[flagF] = (a[wordW-1] != b[wordW-1]) && (res[wordW-1] != a[wordW-1]);
				setCompareFlags(a, b);
			end
			opCmp: begin
				writes = 1'b0;
				setCompareFlags(a, b);
			end
			opAnd:   res = a & b;
			opOr:    res = a | b;
			opXor:   res = a ^ b;
			opNot:   res = ~a;
			opLsh:   res = a << 1;
			opRsh:   res = a >> 1;
			opArsh:  res = $signed(a) >>> 1;
			default: writes = 1'b0;
		endcase
		if (writes) begin
			mRegs[i.rdest] = res;
			expResult = res;
			expValid = 1'b1;
		end
	endtask

	// Sees the same inputs as the DUT on each edge.
	always @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < numRegs; r++) begin
				mRegs[r] = '0;
			end
			mFlags = '0;
			expResult = '0;
			expValid = 1'b0;
			checking = 1'b1;
		end else begin
			expValid = 1'b0;
			if (instValid) begin
				modelExec(inst);
			end
		end
	end

	// ----------------------------------------
	// Checks.
	// ----------------------------------------

	task automatic reportMismatch(input string sigName, input logic [15:0] got,
		input logic [15:0] exp);
		$display("Test FAILED");
		$fatal(1, "Mismatch at %0t ns: %s is %h, expected %h", $time, sigName, got, exp);
	endtask

	task automatic reportCheckerFail();
		$display("Test FAILED");
		$fatal(1, "An assertion in the bound execUnitChk checker failed.");
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clk) begin
		if (checking) begin
			assert (resultValid === expValid)
				else reportMismatch("resultValid", 16'(resultValid), 16'(expValid));
			assert (flags === mFlags)
				else reportMismatch("flags", 16'(flags), 16'(mFlags));
			assert (result === expResult)
				else reportMismatch("result", result, expResult);
			assert (!u_execUnit.u_execUnitChk.anyFail)
				else reportCheckerFail();
		end
	end

	initial begin
		#(totalInsts * clkPeriod * 2 + resetCycles * clkPeriod);
		$display("Test FAILED");
		$fatal(1, "Timeout: the tests did not finish in the allowed time.");
	end

	// ----------------------------------------
	// Stimulus.
	// ----------------------------------------

	task automatic issue(input opCodeT op, input regIdxT rd, input regIdxT rs,
		input logic ui, input immT im);
		instT next;
		next.opCode = op;
		next.rdest = rd;
		next.rsrc = rs;
		next.useImm = ui;
		next.imm = im;
		@(posedge clk);
		inst <= next;
		instValid <= 1'b1;
	endtask

	initial begin
		rst = 1'b1;
		instValid = 1'b0;
		inst = '0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;

		// Zero read of r0 right after reset.
		issue(opAdd, 4'd0, 4'd0, 1'b1, 8'sh00);

		// Immediate loads, about half of them negative.
		for (int r = 0; r < numLoads; r++) begin
			issue(opAdd, regIdxT'(r), 4'd0, 1'b1, immT'(randBits(8)));
		end

		// Build 0x7fff, then cross the signed and unsigned limits.
		issue(opSub, 4'd14, 4'd14, 1'b0, 8'sh00);
		issue(opAdd, 4'd14, 4'd0, 1'b1, 8'shff);
		issue(opRsh, 4'd14, 4'd0, 1'b0, 8'sh00);
		issue(opAdd, 4'd14, 4'd0, 1'b1, 8'sh01);
		issue(opSub, 4'd14, 4'd0, 1'b1, 8'sh01);
		issue(opAdd, 4'd14, 4'd0, 1'b1, 8'shff);
		issue(opSub, 4'd13, 4'd13, 1'b0, 8'sh00);
		issue(opAdd, 4'd13, 4'd0, 1'b1, 8'shff);
		for (int n = 0; n < numArith; n++) begin
			issue(randBits(1) ? opSub : opAdd, regIdxT'(randBits(4)), regIdxT'(randBits(4)),
				1'b0, 8'sh00);
		end

		// Compare with r1 = 5 and r2 = -3, carry and overflow set beforehand.
		issue(opSub, 4'd1, 4'd1, 1'b0, 8'sh00);
		issue(opAdd, 4'd1, 4'd0, 1'b1, 8'sh05);
		issue(opSub, 4'd2, 4'd2, 1'b0, 8'sh00);
		issue(opAdd, 4'd2, 4'd0, 1'b1, 8'shfd);
		issue(opSub, 4'd14, 4'd14, 1'b0, 8'sh00);
		issue(opAdd, 4'd14, 4'd0, 1'b1, 8'shff);
		issue(opRsh, 4'd14, 4'd0, 1'b0, 8'sh00);
		issue(opAdd, 4'd14, 4'd0, 1'b1, 8'sh01);
		// 0x8000 - 1 leaves both C and F set.
		issue(opSub, 4'd14, 4'd0, 1'b1, 8'sh01);
		issue(opCmp, 4'd1, 4'd2, 1'b0, 8'sh00);
		issue(opCmp, 4'd2, 4'd1, 1'b0, 8'sh00);
		issue(opCmp, 4'd1, 4'd1, 1'b0, 8'sh00);
		issue(opCmp, 4'd2, 4'd0, 1'b1, 8'shfd);
		for (int n = 0; n < numCmp; n++) begin
			issue(opCmp, regIdxT'(randBits(4)), regIdxT'(randBits(4)), randBits(1) != 0,
				immT'(randBits(8)));
		end
		issue(opAdd, 4'd1, 4'd0, 1'b1, 8'sh00);
		issue(opAdd, 4'd2, 4'd0, 1'b1, 8'sh00);

		// Logic and shift opcodes, four of each.
		for (int k = 0; k < 7; k++) begin
			for (int n = 0; n < numLogic / 7; n++) begin
				issue(opCodeT'(int'(opAnd) + k), regIdxT'(randBits(4)), regIdxT'(randBits(4)),
					randBits(1) != 0, immT'(randBits(8)));
			end
		end
		// Sign fill from -128.
		issue(opSub, 4'd5, 4'd5, 1'b0, 8'sh00);
		issue(opAdd, 4'd5, 4'd0, 1'b1, 8'sh80);
		issue(opArsh, 4'd5, 4'd0, 1'b0, 8'sh00);
		issue(opArsh, 4'd5, 4'd0, 1'b0, 8'sh00);
		issue(opRsh, 4'd5, 4'd0, 1'b0, 8'sh00);

		// Back-to-back reads of a fresh destination.
		issue(opSub, 4'd6, 4'd6, 1'b0, 8'sh00);
		issue(opAdd, 4'd6, 4'd0, 1'b1, 8'sh03);
		issue(opAdd, 4'd7, 4'd6, 1'b0, 8'sh00);
		issue(opAdd, 4'd6, 4'd6, 1'b0, 8'sh00);
		issue(opXor, 4'd7, 4'd6, 1'b0, 8'sh00);

		// Undefined codes, then read back what they named.
		for (int c = 10; c < 10 + numUndef; c++) begin
			issue(opCodeT'(c), 4'd6 + regIdxT'(c % 2), regIdxT'(randBits(4)), randBits(1) != 0,
				immT'(randBits(8)));
		end
		issue(opAdd, 4'd6, 4'd0, 1'b1, 8'sh00);
		issue(opAdd, 4'd7, 4'd0, 1'b1, 8'sh00);

		@(posedge clk);
		instValid <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (!u_execUnit.u_execUnitChk.anyFail) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "An assertion in the bound execUnitChk checker failed.");
		end
	end

endmodule

// ==== verif/execUnit_chk.sv ====
`timescale 1ns/1ps

module execUnitChk import aluPkg::*, cpuPkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  instValid,
	input instT  inst,
	input logic  resultValid,
	input flagsT flags
);

	// ----------------------------------------
	// Opcode classes.
	// ----------------------------------------

	logic writeOp;
	logic cmpOp;
	logic quietOp;

	// Every defined code except CMP stores a result.
	assign writeOp = (inst.opCode <= opArsh) && (inst.opCode != opCmp);
	assign cmpOp   = inst.opCode == opCmp;
	// Logic, shifts and the undefined codes all sit at or above opAnd.
	assign quietOp = inst.opCode >= opAnd;

	// One sticky bit per assertion, read by the testbench.
	logic badReset = 1'b0;
	logic badValid = 1'b0;
	logic badIdle  = 1'b0;
	logic badQuiet = 1'b0;
	logic badCmp   = 1'b0;
	logic anyFail;

	assign anyFail = badReset | badValid | badIdle | badQuiet | badCmp;

	// ----------------------------------------
	// Output timing.
	// ----------------------------------------

	resetLow: assert property (@(posedge clk) rst |=> !resultValid)
		else begin
			badReset = 1'b1;
			$error("resultValid was high right after a reset cycle");
		end

	validAfterWrite: assert property (@(posedge clk) disable iff (rst)
		instValid && writeOp |=> resultValid)
		else begin
			badValid = 1'b1;
			$error("resultValid missing one cycle after a writing instruction");
		end

	validOnlyAfterWrite: assert property (@(posedge clk) disable iff (rst)
		!(instValid && writeOp) |=> !resultValid)
		else begin
			badIdle = 1'b1;
			$error("resultValid high without a writing instruction before it");
		end

	// ----------------------------------------
	// Flag update rules.
	// ----------------------------------------

	flagsHold: assert property (@(posedge clk) disable iff (rst)
		instValid && quietOp |=> $stable(flags))
		else begin
			badQuiet = 1'b1;
			$error("flags changed after a logic, shift or undefined opcode");
		end

	// CMP touches L, Z and N only.
	cmpKeepsCarry: assert property (@(posedge clk) disable iff (rst)
		instValid && cmpOp |=> $stable(flags[flagC]) && $stable(flags[flagF]))
		else begin
			badCmp = 1'b1;
			$error("C or F changed after CMP");
		end

endmodule

bind execUnit execUnitChk u_execUnitChk (
	.clk         (clk),
	.rst         (rst),
	.instValid   (instValid),
	.inst        (inst),
	.resultValid (resultValid),
	.flags       (flags)
);

// ==== design/execUnit.sv ====
`timescale 1ns/1ps

module execUnit import aluPkg::*, cpuPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  instValid,
	input  instT  inst,
	output wordT  result,
	output logic  resultValid,
	output flagsT flags
);

	// ----------------------------------------
	// Register read.
	// ----------------------------------------

	wordT rdData;
	wordT rsData;
	logic wrEn;
	wordT aluOut;

	regFile u_regFile (
		.clk    (clk),
		.rst    (rst),
		.rdIdx  (inst.rdest),
		.rsIdx  (inst.rsrc),
		.wrEn   (wrEn),
		.wrIdx  (inst.rdest),
		.wrData (aluOut),
		.rdData (rdData),
		.rsData (rsData)
	);

	// ----------------------------------------
	// Source operand.
	// ----------------------------------------

	wordT immExt;
	wordT srcOp;

	// Sign-extend the short immediate to a full word.
	assign immExt = {{(wordW-immW){inst.imm[immW-1]}}, inst.imm};

	assign srcOp = inst.useImm ? immExt : rsData;

	// ----------------------------------------
	// ALU.
	// ----------------------------------------

	flagsT aluFlags;
	flagsT flagMask;
	logic  writesReg;

	alu u_alu (
		.opA       (rdData),
		.opB       (srcOp),
		.opCode    (inst.opCode),
		.aluOut    (aluOut),
		.aluFlags  (aluFlags),
		.flagMask  (flagMask),
		.writesReg (writesReg)
	);

	// CMP and undefined codes never touch the register file.
	assign wrEn = instValid && writesReg;

	// ----------------------------------------
	// Status register.
	// ----------------------------------------

	// The mask is zero for opcodes that leave the flags alone.
	flagReg u_flagReg (
		.clk      (clk),
		.rst      (rst),
		.update   (instValid),
		.newFlags (aluFlags),
		.mask     (flagMask),
		.flags    (flags)
	);

	// ----------------------------------------
	// Output register.
	// ----------------------------------------

	// Result is captured on the same edge as the writeback.
	// resultValid pulses once per stored result.
	always_ff @(posedge clk) begin
		if (rst) begin
			result      <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= wrEn;
			if (wrEn) begin
				result <= aluOut;
			end
		end
	end

endmodule

// ==== design/flagReg.sv ====
`timescale 1ns/1ps

module flagReg import aluPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  update,
	input  flagsT newFlags,
	input  flagsT mask,
	output flagsT flags
);

	// Processor status register.
	// Branch logic would read the flags from here.

	flagsT flagsQ;
	flagsT flagsNext;

	// Masked merge, so flags outside the mask keep their old value.
	assign flagsNext = (flagsQ & ~mask) | (newFlags & mask);

	always_ff @(posedge clk) begin
		if (rst) begin
			flagsQ <= '0;
		end else if (update) begin
			flagsQ <= flagsNext;
		end
	end

	assign flags = flagsQ;

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile import aluPkg::*, cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  regIdxT rdIdx,
	input  regIdxT rsIdx,
	input  logic   wrEn,
	input  regIdxT wrIdx,
	input  wordT   wrData,
	output wordT   rdData,
	output wordT   rsData
);

	// ----------------------------------------
	// Storage.
	// ----------------------------------------

	wordT regs [numRegs];

	// ----------------------------------------
	// Read ports.
	// ----------------------------------------

	// Both reads are combinational.
	// A write shows up on the read ports in the cycle after the edge.
	assign rdData = regs[rdIdx];
	assign rsData = regs[rsIdx];

	// ----------------------------------------
	// Write port.
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import aluPkg::*; (
	input  wordT   opA,
	input  wordT   opB,
	input  opCodeT opCode,
	output wordT   aluOut,
	output flagsT  aluFlags,
	output flagsT  flagMask,
	output logic   writesReg
);

	// ----------------------------------------
	// Shared adder.
	// ----------------------------------------

	logic             isSub;
	wordT             addB;
	logic [wordW:0]   sum;
	wordT             sumWord;

	// SUB and CMP both subtract, as opA + ~opB + 1.
	assign isSub = (opCode == opSub) || (opCode == opCmp);

	assign addB = isSub ? ~opB : opB;

	assign sum = {1'b0, opA} + {1'b0, addB} + {{wordW{1'b0}}, isSub};

	assign sumWord = sum[wordW-1:0];

	// ----------------------------------------
	// Logic and shift functions.
	// ----------------------------------------

	wordT andOut;
	wordT orOut;
	wordT xorOut;
	wordT notOut;
	wordT lshOut;
	wordT rshOut;
	wordT arshOut;

	assign andOut = opA & opB;
	assign orOut  = opA | opB;
	assign xorOut = opA ^ opB;
	assign notOut = ~opA;

	// Single-bit shifts of Rdest only.
	assign lshOut  = {opA[wordW-2:0], 1'b0};
	assign rshOut  = {1'b0, opA[wordW-1:1]};
	assign arshOut = {opA[wordW-1], opA[wordW-1:1]};

	// ----------------------------------------
	// Flag generation.
	// ----------------------------------------

	// Carry and overflow come from the adder.
	// Overflow means both adder inputs agree in sign and the sum does not.
	assign aluFlags[flagC] = sum[wordW];
	assign aluFlags[flagF] = (opA[wordW-1] == addB[wordW-1]) &&
		(sumWord[wordW-1] != opA[wordW-1]);

	// Compare flags always look at the original operands.
	assign aluFlags[flagL] = opA < opB;
	assign aluFlags[flagZ] = opA == opB;
	assign aluFlags[flagN] = $signed(opA) < $signed(opB);

	// ----------------------------------------
	// Opcode decode.
	// ----------------------------------------

	// Result select, flag mask and writeback all come from this one case.
	always_comb begin
		aluOut    = '0;
		flagMask  = '0;
		writesReg = 1'b0;
		case (opCode)
			opAdd, opSub: begin
				aluOut    = sumWord;
				flagMask  = '1;
				writesReg = 1'b1;
			end
			opCmp: begin
				// Difference is visible on aluOut but never stored.
				aluOut          = sumWord;
				flagMask[flagL] = 1'b1;
				flagMask[flagZ] = 1'b1;
				flagMask[flagN] = 1'b1;
			end
			opAnd: begin
				aluOut    = andOut;
				writesReg = 1'b1;
			end
			opOr: begin
				aluOut    = orOut;
				writesReg = 1'b1;
			end
			opXor: begin
				aluOut    = xorOut;
				writesReg = 1'b1;
			end
			opNot: begin
				aluOut    = notOut;
				writesReg = 1'b1;
			end
			opLsh: begin
				aluOut    = lshOut;
				writesReg = 1'b1;
			end
			opRsh: begin
				aluOut    = rshOut;
				writesReg = 1'b1;
			end
			opArsh: begin
				aluOut    = arshOut;
				writesReg = 1'b1;
			end
			default: begin
				// Undefined codes change nothing.
				aluOut    = '0;
				flagMask  = '0;
				writesReg = 1'b0;
			end
		endcase
	end

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

	// ----------------------------------------
	// Register file geometry.
	// ----------------------------------------

	localparam int numRegs = 16;
	localparam int regIdxW = $clog2(numRegs);

	typedef logic [regIdxW-1:0] regIdxT;

	// Short immediate, sign-extended to a full word in the stage.
	localparam int immW = 8;

	typedef logic signed [immW-1:0] immT;

	// ----------------------------------------
	// Decoded instruction.
	// ----------------------------------------

	// Rdest is both the first operand and the writeback target.
	typedef struct packed {
		aluPkg::opCodeT opCode;
		regIdxT         rdest;
		regIdxT         rsrc;
		logic           useImm;
		immT            imm;
	} instT;

endpackage

// ==== design/aluPkg.sv ====
package aluPkg;

	// ----------------------------------------
	// Datapath word.
	// ----------------------------------------

	localparam int wordW = 16;

	typedef logic [wordW-1:0] wordT;

	// ----------------------------------------
	// Operation codes.
	// ----------------------------------------

	localparam int opW = 4;

	typedef logic [opW-1:0] opCodeT;

	localparam opCodeT opAdd  = 4'd0;
	localparam opCodeT opSub  = 4'd1;
	localparam opCodeT opCmp  = 4'd2;
	localparam opCodeT opAnd  = 4'd3;
	localparam opCodeT opOr   = 4'd4;
	localparam opCodeT opXor  = 4'd5;
	localparam opCodeT opNot  = 4'd6;
	localparam opCodeT opLsh  = 4'd7;
	localparam opCodeT opRsh  = 4'd8;
	localparam opCodeT opArsh = 4'd9;
	// Codes 10 to 15 are not assigned.

	// ----------------------------------------
	// Condition flags.
	// ----------------------------------------

	localparam int numFlags = 5;

	typedef logic [numFlags-1:0] flagsT;

	// Bit positions inside flagsT.
	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

endpackage
